// File: du_pkg.sv
// Debug unit widths, address map, opcodes, breakpoint conditions and packed structs
`default_nettype none

package du_pkg;

  ////////////////////////////////////////////////////////////
  // Widths and limits
  ////////////////////////////////////////////////////////////
  parameter int XLEN_DEF        = 32;
  parameter int MAX_BREAKPOINTS = 8;
  parameter int DBG_ADDR_W      = 16;
  parameter int DU_ADDR_W       = 12;
  parameter int ACK_DELAY_DEF   = 3;

  // Bank select in the top address bits
  parameter logic [DBG_ADDR_W-DU_ADDR_W-1:0] BANK_INTERNAL = 4'h0;
  parameter logic [DBG_ADDR_W-DU_ADDR_W-1:0] BANK_GPRS     = 4'h1;

  // Internal bank offsets, breakpoint pairs have a stride of 2
  parameter logic [DU_ADDR_W-1:0] REG_CTRL    = 12'h000;
  parameter logic [DU_ADDR_W-1:0] REG_HIT     = 12'h001;
  parameter logic [DU_ADDR_W-1:0] REG_BPCTRL0 = 12'h010;
  parameter logic [DU_ADDR_W-1:0] REG_BPDATA0 = 12'h011;

  // GPR bank offsets
  parameter logic [DU_ADDR_W-1:0] REG_NPC = 12'h200;
  parameter logic [DU_ADDR_W-1:0] REG_PPC = 12'h201;

  // Major opcodes, instruction bits 6:2
  parameter logic [4:0] OPC_LOAD   = 5'b00000;
  parameter logic [4:0] OPC_STORE  = 5'b01000;
  parameter logic [4:0] OPC_BRANCH = 5'b11000;

  typedef enum logic [2:0] {
    CC_FETCH    = 3'd0,
    CC_LD_ADR   = 3'd1,
    CC_ST_ADR   = 3'd2,
    CC_LDST_ADR = 3'd3
  } bp_cc_e;

  ////////////////////////////////////////////////////////////
  // Packed structs
  ////////////////////////////////////////////////////////////
  typedef struct packed {
    logic        bubble;
    logic [31:0] instr;
  } insn_t;

  typedef struct packed {
    logic                  strb;
    logic                  we;
    logic [DBG_ADDR_W-1:0] addr;
    logic [XLEN_DEF-1:0]   data;
  } dbg_req_t;

  typedef struct packed {
    logic [31:0] nxt_pc;
    logic [31:0] if_pc;
    logic [31:0] pd_pc;
    logic [31:0] id_pc;
  } pipe_pc_t;

  typedef struct packed {
    insn_t       insn;
    logic        exc_any;
    logic [31:0] adr;
    logic        dmem_ack;
  } mem_stage_t;

  typedef struct packed {
    logic branch_break_ena;
    logic instr_break_ena;
  } dbg_ctrl_t;

  typedef struct packed {
    bp_cc_e     cc;
    logic [1:0] rsvd;
    logic       enabled;
    logic       implemented;
  } bp_ctrl_t;

  typedef struct packed {
    logic                       instr;
    logic                       branch;
    logic [MAX_BREAKPOINTS-1:0] bp;
  } hit_ev_t;

  typedef struct packed {
    logic stall;
    logic stall_if;
    logic latch_nxt_pc;
    logic flush;
  } cpu_ctrl_t;

endpackage

`default_nettype wire

// File: du_ack_timer.sv
// Acknowledge timer counting non-stalled cycles of a pending debug access
`timescale 1ns/1ps
`default_nettype none

module du_ack_timer import du_pkg::*; #(
  parameter int ACK_DELAY = ACK_DELAY_DEF
) (
  input  wire logic clk_i,
  input  wire logic rst_ni,
  input  wire logic start_i,
  input  wire logic hold_i,
  output logic      done_o
);

  logic       busy_q;
  logic       active;
  logic       reached;
  logic [2:0] cnt_q;
  logic [2:0] cnt_d;

  // The start cycle itself counts unless stalled
  assign active  = start_i | busy_q;
  assign cnt_d   = (start_i ? 3'd0 : cnt_q) + {2'b00, ~hold_i};
  assign reached = active & (cnt_d == 3'(ACK_DELAY));

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      busy_q <= 1'b0;
      cnt_q  <= 3'd0;
      done_o <= 1'b0;
    end
    else
    begin
      done_o <= reached;
      if (reached)
      begin
        busy_q <= 1'b0;
        cnt_q  <= 3'd0;
      end
      else if (active)
      begin
        busy_q <= 1'b1;
        cnt_q  <= cnt_d;
      end
    end
  end

  a_done_single : assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_o |=> !done_o);

endmodule

`default_nettype wire

// File: du_access_fsm.sv
// Debug port access FSM producing the write pulse and the acknowledge
`timescale 1ns/1ps
`default_nettype none

module du_access_fsm import du_pkg::*; #(
  parameter int ACK_DELAY = ACK_DELAY_DEF
) (
  input  wire logic     clk_i,
  input  wire logic     rst_ni,
  input  wire dbg_req_t req_i,
  input  wire logic     dbg_stall_i,
  input  wire logic     ex_stall_i,
  output logic          wr_pulse_o,
  output logic          dbg_ack_o
);

  typedef enum logic [1:0] {
    IDLE,
    WAIT,
    DONE
  } state_e;

  state_e state_q;
  state_e state_d;
  logic   valid;
  logic   start;

  // GPR bank only reachable while the CPU is stalled
  assign valid = req_i.strb &
                 ((req_i.addr[DBG_ADDR_W-1:DU_ADDR_W] == BANK_INTERNAL) | dbg_stall_i);

  always_comb
  begin
    state_d    = state_q;
    start      = 1'b0;
    wr_pulse_o = 1'b0;
    case (state_q)
      IDLE:
      begin
        if (valid)
        begin
          start      = 1'b1;
          wr_pulse_o = req_i.we;
          state_d    = WAIT;
        end
      end
      WAIT:
      begin
        if (dbg_ack_o)
          state_d = DONE;
      end
      DONE:
      begin
        // Strobe still held so count again without a new write
        if (valid)
        begin
          start   = 1'b1;
          state_d = WAIT;
        end
        else
          state_d = IDLE;
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      state_q <= IDLE;
    else
      state_q <= state_d;
  end

  du_ack_timer #(
    .ACK_DELAY (ACK_DELAY)
  ) u_ack_timer (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .start_i (start),
    .hold_i  (ex_stall_i),
    .done_o  (dbg_ack_o)
  );

  // Debugger holds the request until it sees the acknowledge
  a_req_held : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q == WAIT && !dbg_ack_o) |-> (req_i.strb && $stable(req_i)));

endmodule

`default_nettype wire

// File: du_bp_match.sv
// Breakpoint address comparators with single-step and branch-break detection
`timescale 1ns/1ps
`default_nettype none

module du_bp_match import du_pkg::*; #(
  parameter int XLEN        = XLEN_DEF,
  parameter int BREAKPOINTS = 3
) (
  input  wire dbg_ctrl_t                              ctrl_i,
  input  wire bp_ctrl_t [MAX_BREAKPOINTS-1:0]         bp_ctrl_i,
  input  wire logic [MAX_BREAKPOINTS-1:0][XLEN-1:0]   bp_data_i,
  input  wire insn_t                                  if_nxt_insn_i,
  input  wire insn_t                                  if_insn_i,
  input  wire pipe_pc_t                               pc_i,
  input  wire mem_stage_t                             mem_i,
  input  wire logic                                   bu_flush_i,
  input  wire logic                                   st_flush_i,
  output hit_ev_t                                     hit_o
);

  logic mem_ok;
  logic mem_read;
  logic mem_write;

  ////////////////////////////////////////////////////////////
  // Instruction stream triggers
  ////////////////////////////////////////////////////////////
  assign hit_o.instr  = ctrl_i.instr_break_ena & ~if_nxt_insn_i.bubble;
  assign hit_o.branch = ctrl_i.branch_break_ena & ~if_insn_i.bubble &
                        (if_insn_i.instr[6:2] == OPC_BRANCH);

  // Only completed, exception-free accesses count
  assign mem_ok    = mem_i.dmem_ack & ~mem_i.exc_any & ~mem_i.insn.bubble;
  assign mem_read  = mem_ok & (mem_i.insn.instr[6:2] == OPC_LOAD);
  assign mem_write = mem_ok & (mem_i.insn.instr[6:2] == OPC_STORE);

  ////////////////////////////////////////////////////////////
  // Per-breakpoint comparators
  ////////////////////////////////////////////////////////////
  for (genvar n = 0; n < MAX_BREAKPOINTS; n++)
  begin : gen_bp
    if (n < BREAKPOINTS)
    begin : gen_impl
      logic fetch_eq;
      logic adr_eq;

      assign fetch_eq = bp_data_i[n] == XLEN'(pc_i.pd_pc);
      assign adr_eq   = bp_data_i[n] == XLEN'(mem_i.adr);

      always_comb
      begin
        if (!bp_ctrl_i[n].enabled || !bp_ctrl_i[n].implemented)
          hit_o.bp[n] = 1'b0;
        else
          case (bp_ctrl_i[n].cc)
            CC_FETCH:    hit_o.bp[n] = fetch_eq & ~bu_flush_i & ~st_flush_i;
            CC_LD_ADR:   hit_o.bp[n] = adr_eq & mem_read;
            CC_ST_ADR:   hit_o.bp[n] = adr_eq & mem_write;
            CC_LDST_ADR: hit_o.bp[n] = adr_eq & (mem_read | mem_write);
            default:     hit_o.bp[n] = 1'b0;
          endcase
      end
    end
    else
    begin : gen_none
      assign hit_o.bp[n] = 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: du_regs.sv
// Debug unit control, hit, breakpoint and debug PC registers with the read mux
`timescale 1ns/1ps
`default_nettype none

module du_regs import du_pkg::*; #(
  parameter int XLEN        = XLEN_DEF,
  parameter int BREAKPOINTS = 3
) (
  input  wire logic                                 clk_i,
  input  wire logic                                 rst_ni,
  input  wire dbg_req_t                             req_i,
  input  wire logic                                 wr_pulse_i,
  input  wire hit_ev_t                              hit_i,
  input  wire pipe_pc_t                             pc_i,
  output dbg_ctrl_t                                 ctrl_o,
  output bp_ctrl_t [MAX_BREAKPOINTS-1:0]            bp_ctrl_o,
  output logic [MAX_BREAKPOINTS-1:0][XLEN-1:0]      bp_data_o,
  output logic                                      hit_any_o,
  output logic [XLEN-1:0]                           dbg_q_o
);

  localparam logic [MAX_BREAKPOINTS-1:0] IMPL_MASK = (1 << BREAKPOINTS) - 1;

  logic [DBG_ADDR_W-DU_ADDR_W-1:0] bank;
  logic [DU_ADDR_W-1:0]            offset;
  logic                            we_int;
  logic                            instr_hit_q;
  logic                            branch_hit_q;
  logic [MAX_BREAKPOINTS-1:0]      bp_hit_q;
  logic [31:0]                     dpc_q;
  logic [XLEN-1:0]                 int_q;

  assign bank   = req_i.addr[DBG_ADDR_W-1:DU_ADDR_W];
  assign offset = req_i.addr[DU_ADDR_W-1:0];
  assign we_int = wr_pulse_i & (bank == BANK_INTERNAL);

  ////////////////////////////////////////////////////////////
  // Control and sticky hit registers
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      ctrl_o <= '0;
    else if (we_int && offset == REG_CTRL)
      ctrl_o <= dbg_ctrl_t'(req_i.data[1:0]);
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      instr_hit_q  <= 1'b0;
      branch_hit_q <= 1'b0;
      bp_hit_q     <= '0;
    end
    else if (we_int && offset == REG_HIT)
    begin
      instr_hit_q  <= req_i.data[0];
      branch_hit_q <= req_i.data[1];
      bp_hit_q     <= req_i.data[4 +: MAX_BREAKPOINTS] & IMPL_MASK;
    end
    else
    begin
      instr_hit_q  <= instr_hit_q | hit_i.instr;
      branch_hit_q <= branch_hit_q | hit_i.branch;
      bp_hit_q     <= bp_hit_q | (hit_i.bp & IMPL_MASK);
    end
  end

  assign hit_any_o = instr_hit_q | branch_hit_q | (|bp_hit_q);

  // Breakpoint and branch triggers sit at ID, single-step at IF
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      dpc_q <= '0;
    else if ((|hit_i.bp) || hit_i.branch)
      dpc_q <= pc_i.id_pc;
    else if (hit_i.instr)
      dpc_q <= pc_i.if_pc;
  end

  ////////////////////////////////////////////////////////////
  // Breakpoint slots
  ////////////////////////////////////////////////////////////
  for (genvar n = 0; n < MAX_BREAKPOINTS; n++)
  begin : gen_bp
    if (n < BREAKPOINTS)
    begin : gen_impl
      logic            en_q;
      bp_cc_e          cc_q;
      logic [XLEN-1:0] data_q;

      always_ff @(posedge clk_i or negedge rst_ni)
      begin
        if (!rst_ni)
        begin
          en_q <= 1'b0;
          cc_q <= CC_FETCH;
        end
        else if (we_int && offset == DU_ADDR_W'(REG_BPCTRL0 + 2 * n))
        begin
          en_q <= req_i.data[1];
          cc_q <= bp_cc_e'(req_i.data[6:4]);
        end
      end

      always_ff @(posedge clk_i or negedge rst_ni)
      begin
        if (!rst_ni)
          data_q <= '0;
        else if (we_int && offset == DU_ADDR_W'(REG_BPDATA0 + 2 * n))
          data_q <= XLEN'(req_i.data);
      end

      assign bp_ctrl_o[n] = '{cc: cc_q, rsvd: 2'b00, enabled: en_q, implemented: 1'b1};
      assign bp_data_o[n] = data_q;
    end
    else
    begin : gen_none
      assign bp_ctrl_o[n] = '0;
      assign bp_data_o[n] = '0;
    end
  end

  ////////////////////////////////////////////////////////////
  // Read path
  ////////////////////////////////////////////////////////////
  always_comb
  begin
    int_q = '0;
    if (offset == REG_CTRL)
      int_q = XLEN'(ctrl_o);
    else if (offset == REG_HIT)
      int_q = XLEN'({bp_hit_q, 2'b00, branch_hit_q, instr_hit_q});
    for (int n = 0; n < MAX_BREAKPOINTS; n++)
    begin
      if (offset == DU_ADDR_W'(REG_BPCTRL0 + 2 * n))
        int_q = XLEN'(bp_ctrl_o[n]);
      if (offset == DU_ADDR_W'(REG_BPDATA0 + 2 * n))
        int_q = bp_data_o[n];
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (bank == BANK_INTERNAL)
      dbg_q_o <= int_q;
    else if (bank == BANK_GPRS && offset == REG_NPC)
      dbg_q_o <= XLEN'(pc_i.nxt_pc);
    else if (bank == BANK_GPRS && offset == REG_PPC)
      dbg_q_o <= XLEN'(dpc_q);
    else
      dbg_q_o <= '0;
  end

endmodule

`default_nettype wire

// File: du_mode_ctrl.sv
// Debug stall tracking, entry and exit pulses and the breakpoint output
`timescale 1ns/1ps
`default_nettype none

module du_mode_ctrl import du_pkg::*; (
  input  wire logic clk_i,
  input  wire logic rst_ni,
  input  wire logic dbg_stall_i,
  input  wire logic ex_stall_i,
  input  wire logic st_flush_i,
  input  wire logic hit_any_i,
  output cpu_ctrl_t cpu_o,
  output logic      dbg_bp_o
);

  logic stall_dly_q;
  logic flush;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      stall_dly_q <= 1'b0;
    else
      stall_dly_q <= dbg_stall_i;
  end

  // Exit flush since memory may have changed while halted
  assign flush = ~dbg_stall_i & stall_dly_q;

  assign cpu_o.stall        = dbg_stall_i;
  assign cpu_o.stall_if     = dbg_stall_i | hit_any_i;
  assign cpu_o.latch_nxt_pc = dbg_stall_i & ~stall_dly_q;
  assign cpu_o.flush        = flush;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      dbg_bp_o <= 1'b0;
    else
      dbg_bp_o <= ~ex_stall_i & ~flush & ~st_flush_i & hit_any_i;
  end

  // Entry and exit pulses last one cycle
  a_latch_single : assert property (@(posedge clk_i) disable iff (!rst_ni)
    cpu_o.latch_nxt_pc |=> !cpu_o.latch_nxt_pc);

  a_flush_single : assert property (@(posedge clk_i) disable iff (!rst_ni)
    cpu_o.flush |=> !cpu_o.flush);

endmodule

`default_nettype wire

// File: du_top.sv
// Debug unit top level connecting access FSM, registers, matcher and mode control
`timescale 1ns/1ps
`default_nettype none

module du_top import du_pkg::*; #(
  parameter int XLEN        = XLEN_DEF,
  parameter int BREAKPOINTS = 3,
  parameter int ACK_DELAY   = ACK_DELAY_DEF
) (
  input  wire logic       clk_i,
  input  wire logic       rst_ni,
  // Debugger port
  input  wire dbg_req_t   dbg_req_i,
  input  wire logic       dbg_stall_i,
  output logic [XLEN-1:0] dbg_q_o,
  output logic            dbg_ack_o,
  output logic            dbg_bp_o,
  // CPU side
  output cpu_ctrl_t       cpu_o,
  input  wire pipe_pc_t   pc_i,
  input  wire insn_t      if_nxt_insn_i,
  input  wire insn_t      if_insn_i,
  input  wire mem_stage_t mem_i,
  input  wire logic       ex_stall_i,
  input  wire logic       bu_flush_i,
  input  wire logic       st_flush_i
);

  logic                                wr_pulse;
  dbg_ctrl_t                           ctrl;
  bp_ctrl_t [MAX_BREAKPOINTS-1:0]      bp_ctrl;
  logic [MAX_BREAKPOINTS-1:0][XLEN-1:0] bp_data;
  hit_ev_t                             hit_ev;
  logic                                hit_any;

  du_access_fsm #(
    .ACK_DELAY (ACK_DELAY)
  ) u_access_fsm (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_i       (dbg_req_i),
    .dbg_stall_i (dbg_stall_i),
    .ex_stall_i  (ex_stall_i),
    .wr_pulse_o  (wr_pulse),
    .dbg_ack_o   (dbg_ack_o)
  );

  du_regs #(
    .XLEN        (XLEN),
    .BREAKPOINTS (BREAKPOINTS)
  ) u_regs (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_i      (dbg_req_i),
    .wr_pulse_i (wr_pulse),
    .hit_i      (hit_ev),
    .pc_i       (pc_i),
    .ctrl_o     (ctrl),
    .bp_ctrl_o  (bp_ctrl),
    .bp_data_o  (bp_data),
    .hit_any_o  (hit_any),
    .dbg_q_o    (dbg_q_o)
  );

  du_bp_match #(
    .XLEN        (XLEN),
    .BREAKPOINTS (BREAKPOINTS)
  ) u_bp_match (
    .ctrl_i        (ctrl),
    .bp_ctrl_i     (bp_ctrl),
    .bp_data_i     (bp_data),
    .if_nxt_insn_i (if_nxt_insn_i),
    .if_insn_i     (if_insn_i),
    .pc_i          (pc_i),
    .mem_i         (mem_i),
    .bu_flush_i    (bu_flush_i),
    .st_flush_i    (st_flush_i),
    .hit_o         (hit_ev)
  );

  du_mode_ctrl u_mode_ctrl (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .dbg_stall_i (dbg_stall_i),
    .ex_stall_i  (ex_stall_i),
    .st_flush_i  (st_flush_i),
    .hit_any_i   (hit_any),
    .cpu_o       (cpu_o),
    .dbg_bp_o    (dbg_bp_o)
  );

endmodule

`default_nettype wire

// File: tb_du.sv
// Testbench for the debug unit with random stimulus, register map model and compare tasks
`timescale 1ns/1ps
`default_nettype none

module tb_du import du_pkg::*; ();

  localparam int BREAKPOINTS = 3;
  localparam int ACK_DELAY   = 3;
  // Full sequence needs about 3300 cycles
  localparam int MAX_CYCLES  = 20000;

  localparam logic [15:0] ADDR_CTRL    = {BANK_INTERNAL, REG_CTRL};
  localparam logic [15:0] ADDR_HIT     = {BANK_INTERNAL, REG_HIT};
  localparam logic [15:0] ADDR_BPCTRL0 = {BANK_INTERNAL, REG_BPCTRL0};
  localparam logic [15:0] ADDR_NPC     = {BANK_GPRS, REG_NPC};
  localparam logic [15:0] ADDR_PPC     = {BANK_GPRS, REG_PPC};
  localparam logic [31:0] HIT_MASK     = 32'h3 | (((32'd1 << BREAKPOINTS) - 1) << 4);

  logic        clk;
  logic        rst_n;
  dbg_req_t    dbg_req;
  logic        dbg_stall;
  logic [31:0] dbg_q;
  logic        dbg_ack;
  logic        dbg_bp;
  cpu_ctrl_t   cpu;
  pipe_pc_t    pc;
  insn_t       if_nxt_insn;
  insn_t       if_insn;
  mem_stage_t  mem;
  logic        ex_stall;
  logic        bu_flush;
  logic        st_flush;

  integer      seed = 66337;
  int          cycles = 0;
  logic        stall_mode;

  // Register map model with values kept as they read back
  logic [31:0] m_ctrl;
  logic [31:0] m_hit;
  logic [31:0] m_bpc [MAX_BREAKPOINTS];
  logic [31:0] m_bpd [MAX_BREAKPOINTS];
  logic [31:0] m_dpc;

  du_top #(
    .XLEN        (32),
    .BREAKPOINTS (BREAKPOINTS),
    .ACK_DELAY   (ACK_DELAY)
  ) u_dut (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .dbg_req_i     (dbg_req),
    .dbg_stall_i   (dbg_stall),
    .dbg_q_o       (dbg_q),
    .dbg_ack_o     (dbg_ack),
    .dbg_bp_o      (dbg_bp),
    .cpu_o         (cpu),
    .pc_i          (pc),
    .if_nxt_insn_i (if_nxt_insn),
    .if_insn_i     (if_insn),
    .mem_i         (mem),
    .ex_stall_i    (ex_stall),
    .bu_flush_i    (bu_flush),
    .st_flush_i    (st_flush)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles > MAX_CYCLES)
    begin
      $display("Timeout: the test did not finish within %0d cycles", MAX_CYCLES);
      abort_run();
    end
  end

  ////////////////////////////////////////////////////////////
  // Failure handling and compare tasks
  ////////////////////////////////////////////////////////////
  task automatic abort_run();
    $display("TESTBENCH FAILED");
    $fatal(1, "Simulation stopped at first error");
  endtask

  task automatic check_data(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp)
    begin
      $display("FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_ctrl(input cpu_ctrl_t exp, input cpu_ctrl_t act);
    if (act !== exp)
    begin
      $display("FAILED at %0t: cpu_o {stall,stall_if,latch_nxt_pc,flush} expected %b, got %b",
               $time, exp, act);
      abort_run();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      $display("FAILED at %0t: %s expected %b, got %b", $time, name, exp, act);
      abort_run();
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Model
  ////////////////////////////////////////////////////////////
  function automatic void model_write(input logic [15:0] addr, input logic [31:0] data);
    int slot;
    slot = (int'(addr) - int'(ADDR_BPCTRL0)) / 2;
    if (addr == ADDR_CTRL)
      m_ctrl = data & 32'h3;
    else if (addr == ADDR_HIT)
      m_hit = data & HIT_MASK;
    else if (addr >= ADDR_BPCTRL0 && addr < ADDR_BPCTRL0 + 16 && slot < BREAKPOINTS)
    begin
      // Even offsets hold control and odd ones data
      if (!addr[0])
        m_bpc[slot] = (data & 32'h72) | 32'h1;
      else
        m_bpd[slot] = data;
    end
  endfunction

  function automatic logic [31:0] expected_read(input logic [15:0] addr);
    int slot;
    slot = (int'(addr) - int'(ADDR_BPCTRL0)) / 2;
    if (addr == ADDR_CTRL)
      return m_ctrl;
    if (addr == ADDR_HIT)
      return m_hit;
    if (addr >= ADDR_BPCTRL0 && addr < ADDR_BPCTRL0 + 16)
      return addr[0] ? m_bpd[slot] : m_bpc[slot];
    if (addr == ADDR_NPC)
      return pc.nxt_pc;
    if (addr == ADDR_PPC)
      return m_dpc;
    return 32'h0;
  endfunction

  // Breakpoint condition on the pipeline inputs currently driven
  function automatic logic bp_condition(input logic [2:0] cc, input logic [31:0] adr);
    logic done_mem;
    logic is_ld;
    logic is_st;
    done_mem = mem.dmem_ack & ~mem.exc_any & ~mem.insn.bubble;
    is_ld    = done_mem && mem.insn.instr[6:2] == OPC_LOAD;
    is_st    = done_mem && mem.insn.instr[6:2] == OPC_STORE;
    case (cc)
      CC_FETCH:    return pc.pd_pc == adr && !bu_flush && !st_flush;
      CC_LD_ADR:   return mem.adr == adr && is_ld;
      CC_ST_ADR:   return mem.adr == adr && is_st;
      CC_LDST_ADR: return mem.adr == adr && (is_ld || is_st);
      default:     return 1'b0;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////
  task automatic step();
    @(posedge clk);
    #2;
  endtask

  // Quiet pipeline with the fetch compare masked by the branch flush
  task automatic pipe_idle();
    if_nxt_insn     = '{bubble: 1'b1, instr: 32'h0};
    if_insn         = '{bubble: 1'b1, instr: 32'h0};
    mem.insn.bubble = 1'b1;
    mem.exc_any     = 1'b0;
    mem.dmem_ack    = 1'b0;
    bu_flush        = 1'b1;
    st_flush        = 1'b0;
  endtask

  task automatic debug_access(input logic we, input logic [15:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
    int run;
    run          = 0;
    dbg_req.strb = 1'b1;
    dbg_req.we   = we;
    dbg_req.addr = addr;
    dbg_req.data = wdata;
    ex_stall     = stall_mode & 1'($random(seed));
    while (run < ACK_DELAY)
    begin
      step();
      if (!ex_stall)
        run++;
      check_bit("dbg_ack_o", run == ACK_DELAY, dbg_ack);
      ex_stall = stall_mode & 1'($random(seed));
    end
    rdata        = dbg_q;
    dbg_req.strb = 1'b0;
    dbg_req.we   = 1'b0;
    ex_stall     = 1'b0;
    // Two low cycles bring the FSM back to IDLE
    repeat (2)
    begin
      step();
      check_bit("dbg_ack_o", 1'b0, dbg_ack);
    end
  endtask

  task automatic debug_write(input logic [15:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    debug_access(1'b1, addr, data, unused);
    model_write(addr, data);
  endtask

  task automatic debug_read(input logic [15:0] addr, output logic [31:0] data);
    debug_access(1'b0, addr, 32'h0, data);
  endtask

  task automatic read_and_check(input logic [15:0] addr);
    logic [31:0] rd;
    debug_read(addr, rd);
    check_data("dbg_q_o", expected_read(addr), rd);
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////
  initial
  begin
    logic [15:0] addr;
    logic [2:0]  cc;
    logic [31:0] bp_adr;
    logic [1:0]  ctrl_v;
    logic        hit;
    logic        ih;
    logic        bh;
    logic        prev;
    logic        nxt;
    int          slot;
    int          op_sel;

    rst_n      = 1'b0;
    dbg_req    = '0;
    dbg_stall  = 1'b0;
    ex_stall   = 1'b0;
    stall_mode = 1'b0;
    pc         = '0;
    mem        = '0;
    pipe_idle();
    m_ctrl = '0;
    m_hit  = '0;
    m_dpc  = '0;
    for (int n = 0; n < MAX_BREAKPOINTS; n++)
    begin
      m_bpc[n] = (n < BREAKPOINTS) ? 32'h1 : 32'h0;
      m_bpd[n] = '0;
    end
    repeat (16) @(posedge clk);
    #2;
    rst_n = 1'b1;
    step();
    check_bit("dbg_ack_o", 1'b0, dbg_ack);
    check_bit("dbg_bp_o", 1'b0, dbg_bp);
    check_ctrl('0, cpu);

    // Random register traffic with random execute stalls
    stall_mode = 1'b1;
    for (int i = 0; i < 120; i++)
    begin
      slot = $unsigned($random(seed)) % 18;
      addr = (slot < 2) ? 16'(slot) : ADDR_BPCTRL0 + 16'(slot - 2);
      if ($random(seed) & 1)
        debug_write(addr, $random(seed));
      else
        read_and_check(addr);
    end
    for (int i = 0; i < 18; i++)
      read_and_check((i < 2) ? 16'(i) : ADDR_BPCTRL0 + 16'(i - 2));
    stall_mode = 1'b0;

    // GPR bank outside debug stall is never acknowledged
    dbg_req = '{strb: 1'b1, we: 1'b0, addr: ADDR_NPC, data: 32'h0};
    repeat (20)
    begin
      step();
      check_bit("dbg_ack_o", 1'b0, dbg_ack);
    end
    dbg_req.strb = 1'b0;
    step();
    step();

    // Address breakpoints
    debug_write(ADDR_CTRL, 32'h0);
    for (int n = 0; n < BREAKPOINTS; n++)
      debug_write(ADDR_BPCTRL0 + 16'(2 * n), 32'h0);
    debug_write(ADDR_HIT, 32'h0);
    for (int i = 0; i < 40; i++)
    begin
      slot   = $unsigned($random(seed)) % BREAKPOINTS;
      cc     = 3'($random(seed));
      bp_adr = $random(seed);
      debug_write(ADDR_BPCTRL0 + 16'(2 * slot), {25'd0, cc, 4'b0010});
      debug_write(ADDR_BPCTRL0 + 16'(2 * slot + 1), bp_adr);
      op_sel           = $unsigned($random(seed)) % 3;
      pc.pd_pc         = ($random(seed) & 1) ? bp_adr : $random(seed);
      pc.id_pc         = $random(seed);
      pc.if_pc         = $random(seed);
      mem.adr          = ($random(seed) & 1) ? bp_adr : $random(seed);
      mem.insn.bubble  = 1'b0;
      mem.insn.instr   = {25'($random(seed)),
                          (op_sel == 0) ? OPC_LOAD : (op_sel == 1) ? OPC_STORE : 5'b00100,
                          2'b11};
      mem.exc_any      = ($unsigned($random(seed)) % 4) == 0;
      mem.dmem_ack     = 1'($random(seed));
      bu_flush         = ($unsigned($random(seed)) % 4) == 0;
      st_flush         = ($unsigned($random(seed)) % 4) == 0;
      hit              = bp_condition(cc, bp_adr);
      step();
      pipe_idle();
      if (hit)
      begin
        m_hit = m_hit | (32'd1 << (4 + slot));
        m_dpc = pc.id_pc;
      end
      check_ctrl({1'b0, hit, 1'b0, 1'b0}, cpu);
      check_bit("dbg_bp_o", 1'b0, dbg_bp);
      step();
      check_bit("dbg_bp_o", hit, dbg_bp);
      read_and_check(ADDR_HIT);
      dbg_stall = 1'b1;
      read_and_check(ADDR_PPC);
      dbg_stall = 1'b0;
      debug_write(ADDR_HIT, 32'h0);
      debug_write(ADDR_BPCTRL0 + 16'(2 * slot), 32'h0);
    end

    // Single-step and branch break
    for (int i = 0; i < 30; i++)
    begin
      ctrl_v = 2'($random(seed));
      debug_write(ADDR_CTRL, {30'd0, ctrl_v});
      bh                 = 1'($random(seed));
      pc.if_pc           = $random(seed);
      pc.id_pc           = $random(seed);
      if_nxt_insn.bubble = 1'($random(seed));
      if_insn.bubble     = 1'($random(seed));
      if_insn.instr      = {25'($random(seed)), bh ? OPC_BRANCH : 5'b01100, 2'b11};
      ih = ctrl_v[0] & ~if_nxt_insn.bubble;
      bh = ctrl_v[1] & ~if_insn.bubble & bh;
      step();
      pipe_idle();
      m_hit = m_hit | {30'd0, bh, ih};
      if (bh)
        m_dpc = pc.id_pc;
      else if (ih)
        m_dpc = pc.if_pc;
      check_ctrl({1'b0, ih | bh, 1'b0, 1'b0}, cpu);
      read_and_check(ADDR_HIT);
      dbg_stall = 1'b1;
      read_and_check(ADDR_PPC);
      dbg_stall = 1'b0;
      debug_write(ADDR_HIT, 32'h0);
      check_ctrl('0, cpu);
    end
    debug_write(ADDR_CTRL, 32'h0);

    // Debug stall entry and exit pulses
    prev = dbg_stall;
    for (int i = 0; i < 200; i++)
    begin
      step();
      nxt       = 1'($random(seed));
      dbg_stall = nxt;
      #1;
      check_ctrl({nxt, nxt, nxt & ~prev, ~nxt & prev}, cpu);
      prev = nxt;
    end
    dbg_stall = 1'b1;
    for (int i = 0; i < 8; i++)
    begin
      pc.nxt_pc = $random(seed);
      read_and_check(ADDR_NPC);
    end
    dbg_stall = 1'b0;
    step();

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
du_pkg.sv
du_ack_timer.sv
du_access_fsm.sv
du_bp_match.sv
du_regs.sv
du_mode_ctrl.sv
du_top.sv
tb_du.sv
